//--- Makefile
# Verilator build of the ECC memory testbench.

SRCS := $(shell grep -v '^+' sources.f) hw/ecc_params.svh

.PHONY: run clean

run: obj_dir/Vecc_mem_tb
	@out="$$(./obj_dir/Vecc_mem_tb 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

obj_dir/Vecc_mem_tb: sources.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sources.f --top-module ecc_mem_tb -o Vecc_mem_tb

clean:
	rm -rf obj_dir

//--- hw/ecc_31_cal.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_31_cal (
    input  logic [`ECC_DATA_WIDTH-1:0]   data_in,
    input  logic [`ECC_PARITY_WIDTH-1:0] parity_in,
    input  logic                         bypass,
    output logic [`ECC_DATA_WIDTH-1:0]   data_out,
    output logic [`ECC_PARITY_WIDTH-1:0] parity_out,
    output logic [`ECC_DATA_WIDTH-1:0]   mask,
    output logic                         sbit_err,
    output logic                         dbit_err
);

    // check-bit column of each data bit, all of odd weight.
    localparam logic [`ECC_PARITY_WIDTH-1:0] SYN_COL [0:`ECC_DATA_WIDTH-1] = '{
        7'b1000011, 7'b1000101, 7'b1000110, 7'b0000111,
        7'b1001001, 7'b1001010, 7'b0001011, 7'b1001100,
        7'b0001101, 7'b0001110, 7'b1001111, 7'b1010001,
        7'b1010010, 7'b0010011, 7'b1010100, 7'b0010101,
        7'b0010110, 7'b1010111, 7'b1011000, 7'b0011001,
        7'b0011010, 7'b1011011, 7'b0011100, 7'b1011101,
        7'b1011110, 7'b0011111, 7'b1100001, 7'b1100010,
        7'b0100011, 7'b1100100, 7'b0100101
    };

    logic [`ECC_PARITY_WIDTH-1:0] syndrome;
    logic                         data_hit;
    logic                         parity_hit;

    // encoder.
    always_comb begin
        parity_out = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (data_in[i]) begin
                parity_out = parity_out ^ SYN_COL[i];
            end
        end
    end

    assign syndrome = parity_in ^ parity_out;

    // one-hot mask for a flipped data bit.
    always_comb begin
        mask = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (syndrome == SYN_COL[i]) begin
                mask[i] = 1'b1;
            end
        end
    end

    assign data_hit   = |mask;
    // single check bit flipped, data is intact.
    assign parity_hit = ($countones(syndrome) == 1);

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = !bypass && (data_hit || parity_hit);
    // nonzero and unlisted.
    assign dbit_err = !bypass && (syndrome != '0) && !data_hit && !parity_hit;

endmodule

//--- hw/ecc_err_log.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_err_log (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           clr,
    input  logic                           err_valid,
    input  ecc_types_pkg::ecc_err_evt_t    err_evt,
    output logic [`ECC_CNT_WIDTH-1:0]      sbit_count,
    output logic [`ECC_CNT_WIDTH-1:0]      dbit_count,
    output logic [`ECC_ADDR_WIDTH-1:0]     last_err_addr
);

    logic is_sbit;
    logic is_dbit;

    assign is_sbit = err_valid && (err_evt.status == ecc_types_pkg::ECC_CORRECTED);
    assign is_dbit = err_valid && (err_evt.status == ecc_types_pkg::ECC_UNCORRECTABLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sbit_count    <= '0;
            dbit_count    <= '0;
            last_err_addr <= '0;
        end else begin
            if (err_valid) begin
                last_err_addr <= err_evt.addr;
            end
            // clear wins over a same-cycle event.
            if (clr) begin
                sbit_count <= '0;
                dbit_count <= '0;
            end else begin
                if (is_sbit && (sbit_count != '1)) begin
                    sbit_count <= sbit_count + 1'b1;
                end
                if (is_dbit && (dbit_count != '1)) begin
                    dbit_count <= dbit_count + 1'b1;
                end
            end
        end
    end

    a_evt_not_ok: assert property (@(posedge clk) disable iff (!rst_n)
        err_valid |-> (err_evt.status != ecc_types_pkg::ECC_OK));

endmodule

//--- hw/ecc_mem_ctrl.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_mem_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  mem_if_pkg::mem_req_t           head,
    input  logic                           not_empty,
    output logic                           pop,
    input  logic                           rsp_credit,
    output logic                           rsp_valid,
    output mem_if_pkg::mem_rsp_t           rsp,
    output logic                           mem_en,
    output logic                           mem_we,
    output logic [`ECC_ADDR_WIDTH-1:0]     mem_addr,
    output ecc_types_pkg::ecc_word_t       mem_wdata,
    input  ecc_types_pkg::ecc_word_t       mem_rdata,
    output logic [`ECC_DATA_WIDTH-1:0]     cal_data,
    output logic [`ECC_PARITY_WIDTH-1:0]   cal_parity,
    output logic                           cal_bypass,
    input  logic [`ECC_DATA_WIDTH-1:0]     cal_data_out,
    input  logic [`ECC_PARITY_WIDTH-1:0]   cal_parity_out,
    input  logic                           cal_sbit,
    input  logic                           cal_dbit,
    output logic                           err_valid,
    output ecc_types_pkg::ecc_err_evt_t    err_evt
);

    localparam int RSP_CNT_W = $clog2(`ECC_RSP_CREDITS + 1);

    typedef enum logic [1:0] {IDLE, CHECK, SCRUB} ctrl_state_e;

    ctrl_state_e                state;
    logic [RSP_CNT_W-1:0]       rsp_cnt;
    mem_if_pkg::mem_op_e        op_q;
    logic [`ECC_ADDR_WIDTH-1:0] addr_q;
    logic                       is_write;
    logic                       raw_write;
    ecc_types_pkg::ecc_status_e chk_status;

    // a response slot is reserved before anything is dequeued.
    assign pop       = (state == IDLE) && not_empty && (rsp_cnt != '0);
    assign is_write  = (head.op == mem_if_pkg::OP_WRITE) || (head.op == mem_if_pkg::OP_WRITE_RAW);
    assign raw_write = (head.op == mem_if_pkg::OP_WRITE_RAW);

    // checker is shared: write data, stored word, then scrub data.
    always_comb begin
        cal_data   = head.wdata;
        cal_parity = head.wparity;
        if (state == CHECK) begin
            cal_data   = mem_rdata.data;
            cal_parity = mem_rdata.parity;
        end else if (state == SCRUB) begin
            cal_data = rsp.rdata;
        end
    end

    assign cal_bypass = !((state == CHECK) && (op_q == mem_if_pkg::OP_READ));

    always_comb begin
        mem_en           = 1'b0;
        mem_we           = 1'b0;
        mem_addr         = head.addr;
        mem_wdata.data   = head.wdata;
        mem_wdata.parity = raw_write ? head.wparity : cal_parity_out;
        if (pop) begin
            mem_en = 1'b1;
            mem_we = is_write;
        end else if (state == SCRUB) begin
            // corrected word goes back re-encoded.
            mem_en           = 1'b1;
            mem_we           = 1'b1;
            mem_addr         = addr_q;
            mem_wdata.data   = rsp.rdata;
            mem_wdata.parity = cal_parity_out;
        end
    end

    always_comb begin
        if (cal_dbit) begin
            chk_status = ecc_types_pkg::ECC_UNCORRECTABLE;
        end else if (cal_sbit) begin
            chk_status = ecc_types_pkg::ECC_CORRECTED;
        end else begin
            chk_status = ecc_types_pkg::ECC_OK;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            rsp_cnt   <= RSP_CNT_W'(`ECC_RSP_CREDITS);
            rsp_valid <= 1'b0;
            err_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            err_valid <= 1'b0;
            rsp_cnt   <= rsp_cnt - RSP_CNT_W'(pop) + RSP_CNT_W'(rsp_credit);
            unique case (state)
                IDLE: begin
                    if (pop && is_write) begin
                        rsp_valid <= 1'b1;
                    end else if (pop) begin
                        state <= CHECK;
                    end
                end
                CHECK: begin
                    rsp_valid <= 1'b1;
                    err_valid <= cal_sbit || cal_dbit;
                    state     <= cal_sbit ? SCRUB : IDLE;
                end
                SCRUB: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            op_q   <= head.op;
            addr_q <= head.addr;
        end
        if (pop && is_write) begin
            rsp.op      <= head.op;
            rsp.addr    <= head.addr;
            rsp.rdata   <= head.wdata;
            rsp.rparity <= raw_write ? head.wparity : cal_parity_out;
            rsp.status  <= ecc_types_pkg::ECC_OK;
        end else if (state == CHECK) begin
            rsp.op         <= op_q;
            rsp.addr       <= addr_q;
            rsp.rdata      <= cal_data_out;
            rsp.rparity    <= mem_rdata.parity;
            rsp.status     <= chk_status;
            err_evt.status <= chk_status;
            err_evt.addr   <= addr_q;
        end
    end

    a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(cal_sbit && cal_dbit));

    // requester never returns more than it was given.
    a_rsp_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_cnt <= RSP_CNT_W'(`ECC_RSP_CREDITS));

endmodule

//--- hw/ecc_mem_top.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_mem_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  mem_if_pkg::mem_req_t        req,
    output logic                        req_credit,
    output logic                        rsp_valid,
    output mem_if_pkg::mem_rsp_t        rsp,
    input  logic                        rsp_credit,
    input  logic                        clr_stats,
    output logic [`ECC_CNT_WIDTH-1:0]   sbit_count,
    output logic [`ECC_CNT_WIDTH-1:0]   dbit_count,
    output logic [`ECC_ADDR_WIDTH-1:0]  last_err_addr
);

    mem_if_pkg::mem_req_t             head;
    logic                             not_empty;
    logic                             pop;
    logic                             mem_en;
    logic                             mem_we;
    logic [`ECC_ADDR_WIDTH-1:0]       mem_addr;
    ecc_types_pkg::ecc_word_t         mem_wdata;
    ecc_types_pkg::ecc_word_t         mem_rdata;
    logic [`ECC_DATA_WIDTH-1:0]       cal_data;
    logic [`ECC_PARITY_WIDTH-1:0]     cal_parity;
    logic                             cal_bypass;
    logic [`ECC_DATA_WIDTH-1:0]       cal_data_out;
    logic [`ECC_PARITY_WIDTH-1:0]     cal_parity_out;
    logic                             cal_sbit;
    logic                             cal_dbit;
    logic                             err_valid;
    ecc_types_pkg::ecc_err_evt_t      err_evt;

    ecc_req_fifo #(
        .DEPTH (`ECC_REQ_CREDITS)
    ) u_req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (req_valid),
        .push_data (req),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .credit    (req_credit)
    );

    ecc_mem_ctrl u_mem_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .head           (head),
        .not_empty      (not_empty),
        .pop            (pop),
        .rsp_credit     (rsp_credit),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .mem_en         (mem_en),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .cal_data       (cal_data),
        .cal_parity     (cal_parity),
        .cal_bypass     (cal_bypass),
        .cal_data_out   (cal_data_out),
        .cal_parity_out (cal_parity_out),
        .cal_sbit       (cal_sbit),
        .cal_dbit       (cal_dbit),
        .err_valid      (err_valid),
        .err_evt        (err_evt)
    );

    ecc_sram u_sram (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    // mask is only of interest when probing the checker alone.
    ecc_31_cal u_ecc_cal (
        .data_in    (cal_data),
        .parity_in  (cal_parity),
        .bypass     (cal_bypass),
        .data_out   (cal_data_out),
        .parity_out (cal_parity_out),
        .mask       (),
        .sbit_err   (cal_sbit),
        .dbit_err   (cal_dbit)
    );

    ecc_err_log u_err_log (
        .clk           (clk),
        .rst_n         (rst_n),
        .clr           (clr_stats),
        .err_valid     (err_valid),
        .err_evt       (err_evt),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

endmodule

//--- hw/ecc_params.svh
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// codeword layout.
`define ECC_DATA_WIDTH   31
`define ECC_PARITY_WIDTH 7

// 64 words.
`define ECC_ADDR_WIDTH   6

// flow control.
`define ECC_REQ_CREDITS  4
`define ECC_RSP_CREDITS  2

`define ECC_CNT_WIDTH    16

`endif

//--- hw/ecc_req_fifo.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_req_fifo #(
    parameter int DEPTH = `ECC_REQ_CREDITS
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  mem_if_pkg::mem_req_t push_data,
    input  logic                 pop,
    output mem_if_pkg::mem_req_t head,
    output logic                 not_empty,
    output logic                 credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mem_if_pkg::mem_req_t buf_q [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 do_pop;

    assign not_empty = (count != '0);
    assign do_pop    = pop && not_empty;
    assign head      = buf_q[rd_ptr];
    // every dequeue hands a slot back to the requester.
    assign credit    = do_pop;

    always_ff @(posedge clk) begin
        if (push) begin
            buf_q[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !do_pop) begin
                count <= count + 1'b1;
            end else if (!push && do_pop) begin
                count <= count - 1'b1;
            end
        end
    end

    // requester pushed without holding a credit.
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count != CNT_W'(DEPTH)));

endmodule

//--- hw/ecc_sram.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_sram (
    input  logic                            clk,
    input  logic                            en,
    input  logic                            we,
    input  logic [`ECC_ADDR_WIDTH-1:0]      addr,
    input  ecc_types_pkg::ecc_word_t        wdata,
    output ecc_types_pkg::ecc_word_t        rdata
);

    localparam int WORDS = 1 << `ECC_ADDR_WIDTH;

    ecc_types_pkg::ecc_word_t mem_q [WORDS];

    // single port, read data one cycle after en.
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem_q[addr] <= wdata;
            end else begin
                rdata <= mem_q[addr];
            end
        end
    end

endmodule

//--- hw/ecc_types_pkg.sv
`include "ecc_params.svh"

package ecc_types_pkg;

    // stored codeword, data in the upper bits.
    typedef struct packed {
        logic [`ECC_DATA_WIDTH-1:0]   data;
        logic [`ECC_PARITY_WIDTH-1:0] parity;
    } ecc_word_t;

    // result of a checked read.
    typedef enum logic [1:0] {
        ECC_OK            = 2'd0,
        ECC_CORRECTED     = 2'd1,
        ECC_UNCORRECTABLE = 2'd2
    } ecc_status_e;

    // one per corrected or uncorrectable read.
    typedef struct packed {
        ecc_status_e                status;
        logic [`ECC_ADDR_WIDTH-1:0] addr;
    } ecc_err_evt_t;

endpackage

//--- hw/mem_if_pkg.sv
`include "ecc_params.svh"

package mem_if_pkg;

    // raw ops skip the encoder and checker.
    typedef enum logic [1:0] {
        OP_READ      = 2'd0,
        OP_WRITE     = 2'd1,
        OP_READ_RAW  = 2'd2,
        OP_WRITE_RAW = 2'd3
    } mem_op_e;

    // wparity only matters for OP_WRITE_RAW.
    typedef struct packed {
        mem_op_e                      op;
        logic [`ECC_ADDR_WIDTH-1:0]   addr;
        logic [`ECC_DATA_WIDTH-1:0]   wdata;
        logic [`ECC_PARITY_WIDTH-1:0] wparity;
    } mem_req_t;

    typedef struct packed {
        mem_op_e                      op;
        logic [`ECC_ADDR_WIDTH-1:0]   addr;
        logic [`ECC_DATA_WIDTH-1:0]   rdata;
        logic [`ECC_PARITY_WIDTH-1:0] rparity;
        ecc_types_pkg::ecc_status_e   status;
    } mem_rsp_t;

endpackage

//--- sources.f
+incdir+hw
hw/ecc_types_pkg.sv
hw/mem_if_pkg.sv
hw/ecc_31_cal.sv
hw/ecc_req_fifo.sv
hw/ecc_sram.sv
hw/ecc_mem_ctrl.sv
hw/ecc_err_log.sv
hw/ecc_mem_top.sv
tests/ecc_mem_tb.sv

//--- tests/ecc_mem_tb.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_mem_tb;

    localparam int TIMEOUT = 200;
    localparam int RET_GAP = 3;

    logic                         clk;
    logic                         rst_n;
    logic                         req_valid;
    mem_if_pkg::mem_req_t         req;
    logic                         req_credit;
    logic                         rsp_valid;
    mem_if_pkg::mem_rsp_t         rsp;
    logic                         rsp_credit;
    logic                         clr_stats;
    logic [`ECC_CNT_WIDTH-1:0]    sbit_count;
    logic [`ECC_CNT_WIDTH-1:0]    dbit_count;
    logic [`ECC_ADDR_WIDTH-1:0]   last_err_addr;

    int                           seed = 32'h55264829;
    int                           req_credits = `ECC_REQ_CREDITS;
    int                           owed = 0;
    int                           ret_delay = RET_GAP;
    logic                         hold_credits = 1'b0;
    int                           exp_sbit = 0;
    int                           exp_dbit = 0;
    mem_if_pkg::mem_rsp_t         rsp_q [$];

    ecc_mem_top u_ecc_mem_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .req_credit    (req_credit),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_credit    (rsp_credit),
        .clr_stats     (clr_stats),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // outputs are sampled mid-cycle.
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (rsp_valid === 1'b1) begin
                rsp_q.push_back(rsp);
                owed++;
            end
            if (req_credit === 1'b1) begin
                req_credits++;
            end
        end
    end

    // response side hands each credit back a few cycles later.
    initial begin
        rsp_credit = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            rsp_credit = 1'b0;
            if (!hold_credits && owed > 0) begin
                if (ret_delay == 0) begin
                    rsp_credit = 1'b1;
                    owed--;
                    ret_delay = RET_GAP;
                end else begin
                    ret_delay--;
                end
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run(string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // columns are the 6-bit values that are not powers of two, in order.
    // bit 6 makes the weight odd.
    function automatic logic [`ECC_PARITY_WIDTH-1:0] col_of(int bit_idx);
        int                           v;
        int                           n;
        logic [`ECC_PARITY_WIDTH-1:0] col;
        v = 0;
        n = -1;
        while (n < bit_idx) begin
            v++;
            if ($countones(v[5:0]) > 1) begin
                n++;
            end
        end
        col[5:0] = v[5:0];
        col[6]   = ~^v[5:0];
        return col;
    endfunction

    function automatic logic [`ECC_PARITY_WIDTH-1:0] ref_parity(logic [`ECC_DATA_WIDTH-1:0] d);
        logic [`ECC_PARITY_WIDTH-1:0] p;
        p = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (d[i]) begin
                p = p ^ col_of(i);
            end
        end
        return p;
    endfunction

    task automatic send_req(mem_if_pkg::mem_op_e op, logic [`ECC_ADDR_WIDTH-1:0] addr,
                            logic [`ECC_DATA_WIDTH-1:0] wdata,
                            logic [`ECC_PARITY_WIDTH-1:0] wparity);
        int waited;
        waited = 0;
        while (req_credits == 0) begin
            tick();
            waited++;
            assert (waited < TIMEOUT) else abort_run("timeout waiting for a request credit");
        end
        req_valid   = 1'b1;
        req.op      = op;
        req.addr    = addr;
        req.wdata   = wdata;
        req.wparity = wparity;
        req_credits--;
        tick();
        req_valid = 1'b0;
    endtask

    task automatic get_rsp(output mem_if_pkg::mem_rsp_t r);
        int waited;
        waited = 0;
        while (rsp_q.size() == 0) begin
            tick();
            waited++;
            assert (waited < TIMEOUT) else abort_run("timeout waiting for a response");
        end
        r = rsp_q.pop_front();
    endtask

    task automatic access(mem_if_pkg::mem_op_e op, logic [`ECC_ADDR_WIDTH-1:0] addr,
                          logic [`ECC_DATA_WIDTH-1:0] wdata,
                          logic [`ECC_PARITY_WIDTH-1:0] wparity,
                          output mem_if_pkg::mem_rsp_t r);
        send_req(op, addr, wdata, wparity);
        get_rsp(r);
    endtask

    task automatic check_rsp(mem_if_pkg::mem_rsp_t r, mem_if_pkg::mem_op_e op,
                             logic [`ECC_ADDR_WIDTH-1:0] addr,
                             logic [`ECC_DATA_WIDTH-1:0] data,
                             logic [`ECC_PARITY_WIDTH-1:0] parity,
                             ecc_types_pkg::ecc_status_e st);
        check_val("rsp.op", 64'(r.op), 64'(op));
        check_val("rsp.addr", 64'(r.addr), 64'(addr));
        check_val("rsp.rdata", 64'(r.rdata), 64'(data));
        check_val("rsp.rparity", 64'(r.rparity), 64'(parity));
        check_val("rsp.status", 64'(r.status), 64'(st));
    endtask

    // log updates one cycle after the event.
    task automatic check_counters();
        tick();
        check_val("sbit_count", 64'(sbit_count), 64'(exp_sbit));
        check_val("dbit_count", 64'(dbit_count), 64'(exp_dbit));
    endtask

    task automatic wait_settled();
        int waited;
        waited = 0;
        while (owed != 0 || req_credits != `ECC_REQ_CREDITS) begin
            tick();
            waited++;
            assert (waited < TIMEOUT) else abort_run("credits did not return after traffic");
        end
    endtask

    task automatic reset_values();
        check_val("req_credit", 64'(req_credit), 64'd0);
        check_val("rsp_valid", 64'(rsp_valid), 64'd0);
        check_val("last_err_addr", 64'(last_err_addr), 64'd0);
        check_counters();
    endtask

    task automatic write_then_read();
        mem_if_pkg::mem_rsp_t         r;
        logic [31:0]                  rnd;
        logic [`ECC_ADDR_WIDTH-1:0]   addr;
        logic [`ECC_DATA_WIDTH-1:0]   data;
        for (int n = 0; n < 8; n++) begin
            rnd  = next_rand();
            addr = rnd[`ECC_ADDR_WIDTH-1:0];
            rnd  = next_rand();
            data = rnd[`ECC_DATA_WIDTH-1:0];
            access(mem_if_pkg::OP_WRITE, addr, data, '0, r);
            check_rsp(r, mem_if_pkg::OP_WRITE, addr, data, ref_parity(data),
                      ecc_types_pkg::ECC_OK);
            access(mem_if_pkg::OP_READ, addr, '0, '0, r);
            check_rsp(r, mem_if_pkg::OP_READ, addr, data, ref_parity(data),
                      ecc_types_pkg::ECC_OK);
        end
    endtask

    task automatic single_bit_repair();
        mem_if_pkg::mem_rsp_t         r;
        logic [31:0]                  rnd;
        logic [`ECC_ADDR_WIDTH-1:0]   addr;
        logic [`ECC_DATA_WIDTH-1:0]   data;
        logic [`ECC_DATA_WIDTH-1:0]   flip;
        logic [`ECC_PARITY_WIDTH-1:0] par;
        logic [`ECC_PARITY_WIDTH-1:0] pflip;
        // lower half and nonzero, away from the log's reset value.
        rnd   = next_rand() % 31 + 1;
        addr  = rnd[`ECC_ADDR_WIDTH-1:0];
        rnd   = next_rand();
        data  = rnd[`ECC_DATA_WIDTH-1:0];
        par   = ref_parity(data);
        rnd   = next_rand();
        flip  = 31'd1 << (rnd % 31);
        access(mem_if_pkg::OP_WRITE_RAW, addr, data ^ flip, par, r);
        access(mem_if_pkg::OP_READ, addr, '0, '0, r);
        check_rsp(r, mem_if_pkg::OP_READ, addr, data, par, ecc_types_pkg::ECC_CORRECTED);
        exp_sbit++;
        check_counters();
        check_val("last_err_addr", 64'(last_err_addr), 64'(addr));
        // scrub wrote the clean word back.
        access(mem_if_pkg::OP_READ, addr, '0, '0, r);
        check_rsp(r, mem_if_pkg::OP_READ, addr, data, par, ecc_types_pkg::ECC_OK);
        rnd   = next_rand();
        pflip = 7'd1 << (rnd % 7);
        access(mem_if_pkg::OP_WRITE_RAW, addr, data, par ^ pflip, r);
        access(mem_if_pkg::OP_READ, addr, '0, '0, r);
        check_rsp(r, mem_if_pkg::OP_READ, addr, data, par ^ pflip,
                  ecc_types_pkg::ECC_CORRECTED);
        exp_sbit++;
        check_counters();
    endtask

    task automatic double_bit_detect();
        mem_if_pkg::mem_rsp_t         r;
        logic [31:0]                  rnd;
        logic [`ECC_ADDR_WIDTH-1:0]   addr;
        logic [`ECC_DATA_WIDTH-1:0]   data;
        logic [`ECC_DATA_WIDTH-1:0]   bad;
        logic [`ECC_PARITY_WIDTH-1:0] par;
        int                           b1;
        int                           b2;
        // upper half, so the logged address has to move.
        rnd  = next_rand() % 32 + 32;
        addr = rnd[`ECC_ADDR_WIDTH-1:0];
        rnd  = next_rand();
        data = rnd[`ECC_DATA_WIDTH-1:0];
        par  = ref_parity(data);
        rnd  = next_rand();
        b1   = int'(rnd % 31);
        rnd  = next_rand();
        b2   = (b1 + 1 + int'(rnd % 30)) % 31;
        bad  = data ^ (31'd1 << b1) ^ (31'd1 << b2);
        access(mem_if_pkg::OP_WRITE_RAW, addr, bad, par, r);
        for (int n = 0; n < 2; n++) begin
            access(mem_if_pkg::OP_READ, addr, '0, '0, r);
            check_rsp(r, mem_if_pkg::OP_READ, addr, bad, par,
                      ecc_types_pkg::ECC_UNCORRECTABLE);
            exp_dbit++;
            check_counters();
            check_val("last_err_addr", 64'(last_err_addr), 64'(addr));
        end
    endtask

    task automatic raw_read_bypass();
        mem_if_pkg::mem_rsp_t         r;
        logic [31:0]                  rnd;
        logic [`ECC_ADDR_WIDTH-1:0]   addr;
        logic [`ECC_DATA_WIDTH-1:0]   bad;
        logic [`ECC_PARITY_WIDTH-1:0] par;
        rnd  = next_rand();
        addr = rnd[`ECC_ADDR_WIDTH-1:0];
        rnd  = next_rand();
        bad  = rnd[`ECC_DATA_WIDTH-1:0] ^ 31'h5;
        par  = ref_parity(rnd[`ECC_DATA_WIDTH-1:0]) ^ 7'h10;
        access(mem_if_pkg::OP_WRITE_RAW, addr, bad, par, r);
        check_rsp(r, mem_if_pkg::OP_WRITE_RAW, addr, bad, par, ecc_types_pkg::ECC_OK);
        // stored bits come back untouched and the log stays quiet.
        access(mem_if_pkg::OP_READ_RAW, addr, '0, '0, r);
        check_rsp(r, mem_if_pkg::OP_READ_RAW, addr, bad, par, ecc_types_pkg::ECC_OK);
        check_counters();
    endtask

    task automatic credit_backpressure();
        mem_if_pkg::mem_rsp_t         r;
        logic [31:0]                  rnd;
        logic [`ECC_DATA_WIDTH-1:0]   d0;
        logic [`ECC_DATA_WIDTH-1:0]   d1;
        wait_settled();
        rnd = next_rand();
        d0  = rnd[`ECC_DATA_WIDTH-1:0];
        rnd = next_rand();
        d1  = rnd[`ECC_DATA_WIDTH-1:0];
        hold_credits = 1'b1;
        send_req(mem_if_pkg::OP_WRITE, 6'd12, d0, '0);
        send_req(mem_if_pkg::OP_WRITE, 6'd51, d1, '0);
        send_req(mem_if_pkg::OP_READ, 6'd12, '0, '0);
        send_req(mem_if_pkg::OP_READ, 6'd51, '0, '0);
        repeat (12) tick();
        assert (rsp_q.size() <= `ECC_RSP_CREDITS) else
            abort_run("more responses arrived than response credits allowed");
        assert (req_credits == `ECC_REQ_CREDITS - `ECC_RSP_CREDITS) else
            abort_run("request credits came back while responses were blocked");
        hold_credits = 1'b0;
        get_rsp(r);
        check_rsp(r, mem_if_pkg::OP_WRITE, 6'd12, d0, ref_parity(d0), ecc_types_pkg::ECC_OK);
        get_rsp(r);
        check_rsp(r, mem_if_pkg::OP_WRITE, 6'd51, d1, ref_parity(d1), ecc_types_pkg::ECC_OK);
        get_rsp(r);
        check_rsp(r, mem_if_pkg::OP_READ, 6'd12, d0, ref_parity(d0), ecc_types_pkg::ECC_OK);
        get_rsp(r);
        check_rsp(r, mem_if_pkg::OP_READ, 6'd51, d1, ref_parity(d1), ecc_types_pkg::ECC_OK);
        clr_stats = 1'b1;
        tick();
        clr_stats = 1'b0;
        exp_sbit  = 0;
        exp_dbit  = 0;
        check_counters();
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        clr_stats = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        tick();
        reset_values();
        write_then_read();
        single_bit_repair();
        double_bit_detect();
        raw_read_bypass();
        credit_backpressure();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
